/* logic/iq_entry.sv */
`timescale 1ns/100ps

module iq_entry
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    input  logic              write_i,
    input  dispatch_t         dispatch_i,
    input  cdb_t        [1:0] snoop_i,
    input  logic              issue_i,
    output logic              empty_o,
    output logic              ready_o,
    output word_t       [1:0] src_o,
    output iq_payload_t       payload_o
);

    logic              valid_q;
    src_t        [1:0] src_q;
    src_t        [1:0] src_cur;
    src_t        [1:0] src_nxt;
    iq_payload_t       payload_q;

    // occupancy
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i || issue_i) begin
            valid_q <= 1'b0;
        end else if (write_i) begin
            valid_q <= 1'b1;
        end
    end

    // operand update, a tag seen in the write cycle is caught as well
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_cur[s] = write_i ? dispatch_i.src[s] : src_q[s];
            src_nxt[s] = src_cur[s];
            for (int l = 0; l < 2; l++) begin
                if (!src_cur[s].ready && snoop_i[l].valid
                        && snoop_i[l].wid == src_cur[s].tag) begin
                    src_nxt[s].ready = 1'b1;
                    src_nxt[s].value = snoop_i[l].wdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_i || valid_q) begin
            src_q <= src_nxt;
        end
        if (write_i) begin
            payload_q.op  <= dispatch_i.op;
            payload_q.wid <= dispatch_i.wid;
        end
    end

    assign empty_o   = !valid_q;
    assign ready_o   = valid_q && src_q[0].ready && src_q[1].ready;
    assign src_o[0]  = src_q[0].value;
    assign src_o[1]  = src_q[1].value;
    assign payload_o = payload_q;

endmodule

/* logic/mdu_backend.sv */
`timescale 1ns/100ps

module mdu_backend
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
#(
    parameter int IQ_SIZE = 4
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            flush_i,
    input  dispatch_t [1:0] dispatch_i,
    input  logic      [1:0] dispatch_valid_i,
    output logic            dispatch_ready_o,
    input  cdb_t      [1:0] snoop_i,
    output cdb_t            cdb_o,
    input  logic            cdb_ready_i
);

    logic      req_valid;
    logic      req_ready;
    mdu_req_t  req;
    logic      resp_valid;
    logic      resp_ready;
    mdu_resp_t resp;

    mdu_iq #(
        .IQ_SIZE (IQ_SIZE)
    ) i_mdu_iq (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .snoop_i          (snoop_i),
        .req_valid_o      (req_valid),
        .req_ready_i      (req_ready),
        .req_o            (req)
    );

    mdu_unit i_mdu_unit (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (resp)
    );

    result_queue i_result_queue (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (resp_valid),
        .in_ready_o  (resp_ready),
        .in_i        (resp),
        .out_o       (cdb_o),
        .out_ready_i (cdb_ready_i)
    );

endmodule

/* logic/mdu_bus_pkg.sv */
package mdu_bus_pkg;

    import mdu_types_pkg::*;

    // one source operand, value valid when ready is set
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   value;
    } src_t;

    // decoded instruction as it leaves dispatch
    typedef struct packed {
        mdu_op_e    op;
        rob_id_t    wid;
        src_t [1:0] src;
    } dispatch_t;

    // static part kept in a reservation entry
    typedef struct packed {
        mdu_op_e op;
        rob_id_t wid;
    } iq_payload_t;

    // one common data bus lane
    typedef struct packed {
        logic    valid;
        rob_id_t wid;
        word_t   wdata;
    } cdb_t;

    // issue register to unit
    typedef struct packed {
        mdu_op_e op;
        rob_id_t wid;
        word_t   r0;
        word_t   r1;
    } mdu_req_t;

    typedef struct packed {
        rob_id_t wid;
        word_t   result;
    } mdu_resp_t;

endpackage

/* logic/mdu_iq.sv */
`timescale 1ns/100ps

module mdu_iq
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
#(
    parameter int IQ_SIZE = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  dispatch_t      [1:0] dispatch_i,
    input  logic           [1:0] dispatch_valid_i,
    output logic                 dispatch_ready_o,
    input  cdb_t           [1:0] snoop_i,
    output logic                 req_valid_o,
    input  logic                 req_ready_i,
    output mdu_req_t             req_o
);

    localparam int CNT_W = $clog2(IQ_SIZE + 1);
    localparam int IDX_W = $clog2(IQ_SIZE);

    logic        [IQ_SIZE-1:0]      empty;
    logic        [IQ_SIZE-1:0]      ready;
    logic        [1:0][IQ_SIZE-1:0] alloc_oh;
    word_t       [IQ_SIZE-1:0][1:0] src;
    iq_payload_t [IQ_SIZE-1:0]      payload;
    logic                           sel_valid;
    logic        [IDX_W-1:0]        sel_idx;
    mdu_req_t                       sel_req;
    logic                           issue_load;
    logic                           issue_fire;
    logic        [CNT_W-1:0]        credit_q;
    logic        [CNT_W-1:0]        credit_nxt;
    logic                           req_valid_q;
    mdu_req_t                       req_q;

    // lane 0 takes the lowest free slot, lane 1 the highest
    always_comb begin
        alloc_oh = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (empty[i]) begin
                alloc_oh[0]    = '0;
                alloc_oh[0][i] = 1'b1;
            end
        end
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (empty[i]) begin
                alloc_oh[1]    = '0;
                alloc_oh[1][i] = 1'b1;
            end
        end
    end

    // fixed priority, lowest ready index wins
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign issue_load = !req_valid_q || req_ready_i;
    assign issue_fire = issue_load && sel_valid;

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        logic [1:0] take;

        assign take[0] = alloc_oh[0][i] & dispatch_valid_i[0];
        assign take[1] = alloc_oh[1][i] & dispatch_valid_i[1];

        iq_entry i_iq_entry (
            .clk        (clk),
            .arst_n_i   (arst_n_i),
            .flush_i    (flush_i),
            .write_i    (|take),
            .dispatch_i (take[1] ? dispatch_i[1] : dispatch_i[0]),
            .snoop_i    (snoop_i),
            .issue_i    (issue_fire && sel_idx == IDX_W'(i)),
            .empty_o    (empty[i]),
            .ready_o    (ready[i]),
            .src_o      (src[i]),
            .payload_o  (payload[i])
        );
    end

    // free slot credits, ready only while two slots are guaranteed
    assign credit_nxt = credit_q - CNT_W'(dispatch_valid_i[0]) - CNT_W'(dispatch_valid_i[1])
                        + CNT_W'(issue_fire);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_q         <= CNT_W'(IQ_SIZE);
            dispatch_ready_o <= 1'b1;
        end else if (flush_i) begin
            credit_q         <= CNT_W'(IQ_SIZE);
            dispatch_ready_o <= 1'b1;
        end else begin
            credit_q         <= credit_nxt;
            dispatch_ready_o <= credit_nxt >= CNT_W'(2);
        end
    end

    always_comb begin
        sel_req.op  = payload[sel_idx].op;
        sel_req.wid = payload[sel_idx].wid;
        sel_req.r0  = src[sel_idx][0];
        sel_req.r1  = src[sel_idx][1];
    end

    // issue register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_q <= 1'b0;
        end else if (flush_i) begin
            req_valid_q <= 1'b0;
        end else if (issue_load) begin
            req_valid_q <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_load) begin
            req_q <= sel_req;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

endmodule

/* logic/mdu_types_pkg.sv */
package mdu_types_pkg;

    // scalar widths
    localparam int WORD_W   = 32;
    localparam int ROB_ID_W = 5;

    // one data word on the CDB or in an operand slot
    typedef logic [WORD_W-1:0] word_t;

    // reorder buffer tag, names where a result goes
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // multiply/divide operation select
    typedef enum logic [1:0] {
        MDU_MUL  = 2'd0,
        MDU_MULH = 2'd1,
        MDU_DIV  = 2'd2,
        MDU_REM  = 2'd3
    } mdu_op_e;

endpackage

/* logic/mdu_unit.sv */
`timescale 1ns/100ps

module mdu_unit
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      flush_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  mdu_req_t  req_i,
    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output mdu_resp_t resp_o
);

    localparam int DIV_STEPS = 32;

    typedef enum logic [1:0] {IDLE, MUL, DIV, DONE} state_e;

    state_e         state_q;
    logic    [5:0]  cnt_q;
    mdu_op_e        op_q;
    rob_id_t        wid_q;
    word_t          a_q;
    word_t          b_q;
    logic    [63:0] product_q;
    logic    [63:0] mul_full;
    logic           mul_sgn;
    word_t          quo_q;
    word_t          rem_q;
    word_t          div_q;
    logic    [32:0] rem_shift;
    logic    [32:0] diff;
    word_t          div_result;
    word_t          result_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (req_valid_i) begin
                        state_q <= (req_i.op == MDU_MUL || req_i.op == MDU_MULH) ? MUL : DIV;
                    end
                end
                MUL: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (cnt_q == 6'd1) state_q <= DONE;
                end
                DIV: begin
                    cnt_q <= cnt_q + 6'd1;
                    if (cnt_q == 6'(DIV_STEPS)) state_q <= DONE;
                end
                DONE: begin
                    if (resp_ready_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // sign extend only for the high signed product
    assign mul_sgn  = op_q == MDU_MULH;
    assign mul_full = {{32{mul_sgn & a_q[31]}}, a_q} * {{32{mul_sgn & b_q[31]}}, b_q};

    // one restoring step on magnitudes
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, div_q};

    // sign fix-up and the two corner cases
    always_comb begin
        if (b_q == '0) begin
            div_result = (op_q == MDU_DIV) ? '1 : a_q;
        end else if (op_q == MDU_DIV) begin
            div_result = (a_q[31] ^ b_q[31]) ? word_t'(-quo_q) : quo_q;
        end else begin
            div_result = a_q[31] ? word_t'(-rem_q) : rem_q;
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    op_q  <= req_i.op;
                    wid_q <= req_i.wid;
                    a_q   <= req_i.r0;
                    b_q   <= req_i.r1;
                    quo_q <= req_i.r0[31] ? (~req_i.r0 + 32'd1) : req_i.r0;
                    div_q <= req_i.r1[31] ? (~req_i.r1 + 32'd1) : req_i.r1;
                    rem_q <= '0;
                end
            end
            MUL: begin
                if (cnt_q == 6'd0) begin
                    product_q <= mul_full;
                end else begin
                    result_q <= (op_q == MDU_MULH) ? product_q[63:32] : product_q[31:0];
                end
            end
            DIV: begin
                if (cnt_q < 6'(DIV_STEPS)) begin
                    rem_q <= diff[32] ? rem_shift[31:0] : diff[31:0];
                    quo_q <= {quo_q[30:0], !diff[32]};
                end else begin
                    result_q <= div_result;
                end
            end
            default: ;
        endcase
    end

    assign req_ready_o   = state_q == IDLE;
    assign resp_valid_o  = state_q == DONE;
    assign resp_o.wid    = wid_q;
    assign resp_o.result = result_q;

endmodule

/* logic/result_queue.sv */
`timescale 1ns/100ps

module result_queue
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      flush_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  mdu_resp_t in_i,
    output cdb_t      out_o,
    input  logic      out_ready_i
);

    localparam int DEPTH = 2;

    rob_id_t       wid_mem  [DEPTH];
    word_t         data_mem [DEPTH];
    logic          wr_ptr_q;
    logic          rd_ptr_q;
    logic    [1:0] count_q;
    logic          push;
    logic          pop;

    assign in_ready_o = count_q != 2'(DEPTH);
    assign push       = in_valid_i && in_ready_o;
    assign pop        = out_o.valid && out_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wid_mem[wr_ptr_q]  <= in_i.wid;
            data_mem[wr_ptr_q] <= in_i.result;
        end
    end

    // head entry drives the cdb lane
    assign out_o.valid = count_q != 2'd0;
    assign out_o.wid   = wid_mem[rd_ptr_q];
    assign out_o.wdata = data_mem[rd_ptr_q];

endmodule

/* mdu_backend.f */
logic/mdu_types_pkg.sv
logic/mdu_bus_pkg.sv
logic/iq_entry.sv
logic/mdu_iq.sv
logic/mdu_unit.sv
logic/result_queue.sv
logic/mdu_backend.sv
tb/mdu_backend_sva.sv
tb/mdu_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mdu_backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module mdu_backend_tb -f mdu_backend.f \
    && ./obj_dir/Vmdu_backend_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

/* tb/mdu_backend_sva.sv */
`timescale 1ns/100ps

module mdu_backend_sva #(
    parameter int W = 32
) (
    input logic         clk,
    input logic         arst_n_i,
    input logic         flush_i,
    input logic         valid_i,
    input logic         ready_i,
    input logic [W-1:0] data_i
);

    // valid holds until the transfer
    a_valid_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i && !ready_i && !flush_i |=> valid_i)
        else $error("valid dropped before the transfer");

    // payload frozen while waiting
    a_data_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i && !ready_i && !flush_i |=> $stable(data_i))
        else $error("payload changed while waiting for ready");

    a_flush_clear: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !valid_i)
        else $error("valid still high one cycle after flush");

endmodule

bind mdu_unit mdu_backend_sva #(.W($bits(req_i))) i_req_sva (
    .clk(clk), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .valid_i(req_valid_i), .ready_i(req_ready_o), .data_i(req_i)
);

bind mdu_unit mdu_backend_sva #(.W($bits(resp_o))) i_resp_sva (
    .clk(clk), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .valid_i(resp_valid_o), .ready_i(resp_ready_i), .data_i(resp_o)
);

bind result_queue mdu_backend_sva #(.W($bits(out_o))) i_out_sva (
    .clk(clk), .arst_n_i(arst_n_i), .flush_i(flush_i),
    .valid_i(out_o.valid), .ready_i(out_ready_i), .data_i(out_o)
);

/* tb/mdu_backend_tb.sv */
`timescale 1ns/100ps

module mdu_backend_tb
    import mdu_types_pkg::*;
    import mdu_bus_pkg::*;
();

    localparam int MAX_LINES = 32;
    localparam int MAX_BC    = 16;
    // result queue held back until this cycle
    localparam int STALL_END = 70;

    logic            clk;
    logic            arst_n_i;
    logic            flush_i;
    dispatch_t [1:0] dispatch;
    logic      [1:0] dispatch_valid;
    logic            dispatch_ready;
    cdb_t            snoop0 = '0;
    cdb_t            snoop1;
    cdb_t            cdb;
    logic            cdb_ready = 1'b0;

    dispatch_t ln_disp [MAX_LINES];
    int        ln_lane [MAX_LINES];
    int        ln_dly  [MAX_LINES][2];
    word_t     exp_by_wid [32];
    logic      known [32];
    logic      flushed [32];
    int        seen [32];
    int        pending_set [32];
    int        pending_sent [32];
    int        bc_due [MAX_BC];
    cdb_t      bc_lane [MAX_BC];
    rob_id_t   bc_owner [MAX_BC];
    logic      bc_done [MAX_BC] = '{default: 1'b0};
    int        bc_cnt;
    int        n_lines;
    int        received = 0;
    int        cycle = 0;
    int        limit = 0;
    int        seed = 23;
    int        err_value = 0;
    int        err_other = 0;
    int        err_tb;
    logic      hold_ready;
    logic      saw_busy = 1'b0;
    logic      expect_first;
    rob_id_t   first_wid;
    int        n_fl;
    int        i;

    mdu_backend #(
        .IQ_SIZE (4)
    ) i_mdu_backend (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_ready_o (dispatch_ready),
        .snoop_i          ({snoop1, snoop0}),
        .cdb_o            (cdb),
        .cdb_ready_i      (cdb_ready)
    );

    always #5 clk = ~clk;

    // cdb arbiter loops our own result back on lane 1
    always_comb begin
        snoop1       = cdb;
        snoop1.valid = cdb.valid && cdb_ready;
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_wid(input rob_id_t got, input rob_id_t exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_input();
        int    fd;
        int    cnt;
        string line;
        int    lane, op, wid, r0, t0, r1, t1, d0, d1;
        word_t v0, v1, ex;
        fd = $fopen("tb/mdu_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%d %d %h %d %h %h %d %h %h %d %d %h",
                              lane, op, wid, r0, t0, v0, r1, t1, v1, d0, d1, ex);
                if (cnt == 12 && n_lines < MAX_LINES) begin
                    ln_lane[n_lines]              = lane;
                    ln_disp[n_lines].op           = mdu_op_e'(op);
                    ln_disp[n_lines].wid          = rob_id_t'(wid);
                    ln_disp[n_lines].src[0].ready = r0 != 0;
                    ln_disp[n_lines].src[0].tag   = rob_id_t'(t0);
                    ln_disp[n_lines].src[0].value = v0;
                    ln_disp[n_lines].src[1].ready = r1 != 0;
                    ln_disp[n_lines].src[1].tag   = rob_id_t'(t1);
                    ln_disp[n_lines].src[1].value = v1;
                    ln_dly[n_lines][0]            = d0;
                    ln_dly[n_lines][1]            = d1;
                    exp_by_wid[rob_id_t'(wid)]    = ex;
                    known[rob_id_t'(wid)]         = 1'b1;
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // put one line on its lane with pending values garbled until broadcast
    task automatic send(input int idx);
        int lane;
        lane = ln_lane[idx];
        dispatch[lane]       = ln_disp[idx];
        dispatch_valid[lane] = 1'b1;
        for (int s = 0; s < 2; s++) begin
            if (!ln_disp[idx].src[s].ready) begin
                dispatch[lane].src[s].value = ~ln_disp[idx].src[s].value;
                if (ln_dly[idx][s] != 0 && bc_cnt < MAX_BC) begin
                    bc_due[bc_cnt]   = cycle + ln_dly[idx][s];
                    bc_lane[bc_cnt]  = '{1'b1, ln_disp[idx].src[s].tag,
                                         ln_disp[idx].src[s].value};
                    bc_owner[bc_cnt] = ln_disp[idx].wid;
                    pending_set[ln_disp[idx].wid]++;
                    bc_cnt++;
                end
            end
        end
    endtask

    task automatic record_result(input cdb_t r);
        if (expect_first) begin
            check_wid(r.wid, first_wid, "first result after the flush");
            expect_first = 1'b0;
        end
        if (flushed[r.wid]) begin
            err_other++;
            $display("stale result for wid %h showed up after the flush", r.wid);
        end else if (!known[r.wid]) begin
            err_other++;
            $display("result for wid %h was never dispatched", r.wid);
        end else if (seen[r.wid] != 0) begin
            err_other++;
            $display("result for wid %h came out a second time", r.wid);
        end else begin
            if (pending_set[r.wid] != pending_sent[r.wid]) begin
                err_other++;
                $display("result for wid %h came before its operands were sent", r.wid);
            end
            check_word(r.wdata, exp_by_wid[r.wid], $sformatf("wid %h result", r.wid));
            seen[r.wid]++;
            received++;
        end
    endtask

    // snoop lane 0 carries at most one broadcast per cycle
    always @(negedge clk) begin : drive_snoop
        logic sent;
        sent   = 1'b0;
        snoop0 = '0;
        for (int k = 0; k < bc_cnt; k++) begin
            if (!sent && !bc_done[k] && bc_due[k] <= cycle) begin
                snoop0      = bc_lane[k];
                bc_done[k]  = 1'b1;
                pending_sent[bc_owner[k]]++;
                sent        = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (cycle < STALL_END) begin
            cdb_ready = 1'b0;
        end else if (hold_ready) begin
            cdb_ready = 1'b1;
        end else begin
            cdb_ready = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (arst_n_i && cdb.valid && cdb_ready) begin
            record_result(cdb);
        end
        if (arst_n_i && !dispatch_ready) begin
            saw_busy = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (limit != 0 && cycle > limit) begin
            $display("timeout after %0d cycles, %0d of %0d results arrived",
                     cycle, received, n_lines);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        dispatch       = '0;
        dispatch_valid = '0;
        hold_ready     = 1'b0;
        expect_first   = 1'b0;
        first_wid      = '0;
        err_tb         = 0;
        bc_cnt         = 0;
        n_lines        = 0;
        for (int w = 0; w < 32; w++) begin
            known[w]        = 1'b0;
            flushed[w]      = 1'b0;
            seen[w]         = 0;
            pending_set[w]  = 0;
            pending_sent[w] = 0;
        end
        read_input();
        if (n_lines == 0) begin
            $display("no stimulus lines could be read from tb/mdu_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            limit = 40 * n_lines + 200;
            repeat (4) @(posedge clk);
            @(negedge clk);
            arst_n_i = 1'b1;

            // a lane 0 line followed by a lane 1 line goes out as a pair
            i = 0;
            while (i < n_lines) begin
                @(negedge clk);
                dispatch_valid = '0;
                if (dispatch_ready) begin
                    send(i);
                    i++;
                    if (i < n_lines && ln_lane[i] == 1 && ln_lane[i-1] == 0) begin
                        send(i);
                        i++;
                    end
                end
            end
            @(negedge clk);
            dispatch_valid = '0;
            while (received < n_lines) @(negedge clk);
            if (!saw_busy) begin
                err_tb++;
                $display("dispatch_ready never fell while results were held back");
            end

            // fill the queue behind a long divide before the flush
            hold_ready = 1'b1;
            repeat (4) @(negedge clk);
            while (!dispatch_ready) @(negedge clk);
            n_fl = 0;
            while (n_fl < 6) begin
                dispatch_valid = '0;
                if (dispatch_ready) begin
                    flushed[5'h1a + n_fl] = 1'b1;
                    flushed[5'h1b + n_fl] = 1'b1;
                    dispatch[0].op        = (n_fl == 0) ? MDU_DIV : MDU_MUL;
                    dispatch[0].wid       = rob_id_t'(5'h1a + n_fl);
                    dispatch[0].src[0]    = '{1'b1, 5'h00, 32'h0000_0100};
                    dispatch[0].src[1]    = '{1'b1, 5'h00, 32'h0000_0003};
                    dispatch[1]           = dispatch[0];
                    dispatch[1].op        = MDU_MUL;
                    dispatch[1].wid       = rob_id_t'(5'h1b + n_fl);
                    dispatch_valid        = 2'b11;
                    n_fl                  = n_fl + 2;
                end
                @(negedge clk);
            end
            dispatch_valid = '0;
            repeat (2) @(negedge clk);
            if (dispatch_ready !== 1'b0) begin
                err_tb++;
                $display("dispatch_ready stayed high while the queue was full");
            end
            first_wid    = 5'h17;
            expect_first = 1'b1;
            flush_i      = 1'b1;
            @(negedge clk);
            flush_i = 1'b0;
            if (dispatch_ready !== 1'b1) begin
                err_tb++;
                $display("dispatch_ready stayed low after the flush");
            end
            repeat (50) @(negedge clk);

            // one fresh multiply must be the first result after the flush
            known[5'h17]       = 1'b1;
            exp_by_wid[5'h17]  = 32'd42;
            dispatch[0].op     = MDU_MUL;
            dispatch[0].wid    = 5'h17;
            dispatch[0].src[0] = '{1'b1, 5'h00, 32'd6};
            dispatch[0].src[1] = '{1'b1, 5'h00, 32'd7};
            dispatch_valid     = 2'b01;
            @(negedge clk);
            dispatch_valid = '0;
            while (seen[5'h17] == 0) @(negedge clk);

            for (int k = 0; k < n_lines; k++) begin
                if (seen[ln_disp[k].wid] != 1) begin
                    err_tb++;
                    $display("wid %h arrived %0d times instead of once",
                             ln_disp[k].wid, seen[ln_disp[k].wid]);
                end
            end
            $display("errors: %0d wrong values, %0d result failures, %0d other failures",
                     err_value, err_other, err_tb);
            if (err_value + err_other + err_tb == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

/* tb/mdu_input.txt */
# lane op wid rdy0 tag0 val0 rdy1 tag1 val1 dly0 dly1 expected (op 0 mul 1 mulh 2 div 3 rem)
# a pending source with delay 0 waits for the result loop-back on cdb lane 1
0 2 00 1 00 00000064 1 00 00000007 0 0 0000000e
1 0 01 0 00 00000000 1 00 00000003 0 0 0000002a
0 0 02 1 00 12345678 1 00 00000010 0 0 23456780
1 1 03 1 00 ffffffff 1 00 ffffffff 0 0 00000000
0 1 04 1 00 80000000 1 00 80000000 0 0 40000000
1 1 05 1 00 7fffffff 1 00 fffffffe 0 0 ffffffff
0 2 06 1 00 00001234 1 00 00000000 0 0 ffffffff
1 3 07 1 00 00001234 1 00 00000000 0 0 00001234
0 2 08 1 00 80000000 1 00 ffffffff 0 0 80000000
1 3 09 1 00 80000000 1 00 ffffffff 0 0 00000000
0 2 0a 1 00 fffffff9 1 00 00000002 0 0 fffffffd
1 3 0b 1 00 fffffff9 1 00 00000002 0 0 ffffffff
0 2 0c 1 00 00000007 1 00 fffffffe 0 0 fffffffd
1 3 0d 1 00 00000007 1 00 fffffffe 0 0 00000001
0 0 0e 0 18 00000009 1 00 00000005 12 0 0000002d
1 0 0f 1 00 00000003 0 19 fffffffc 0 30 fffffff4
0 2 10 0 1a 00000064 0 1b 0000000a 5 20 0000000a
1 3 11 0 1c 00000011 1 00 00000005 3 0 00000002
0 1 12 1 00 00010000 1 00 00010000 0 0 00000001
1 0 13 0 1d 00000100 1 00 00000100 40 0 00010000
0 2 14 1 00 7fffffff 1 00 00000010 0 0 07ffffff
1 3 15 1 00 ffffffef 1 00 00000005 0 0 fffffffe
0 0 16 1 00 ffffffff 1 00 ffffffff 0 0 00000001
